//--- compile.f
design/cpu_pkg.sv
design/cpu_stage_if.sv
design/cpu_host_port.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_stall.sv
design/cpu_pipeline.sv
design/cpu_top.sv
verification/tb_cpu_top.sv

//--- design/cpu_alu.sv
////////////////////////////////////////////////////////////////////////////
// Arithmetic and logic unit
// Add, subtract, bitwise logic and shifts with a zero flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_alu (
	input  cpu_pkg::alu_op_t         op,
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	output logic [cpu_pkg::xlen-1:0] y,
	output logic                     zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0];   // Only the low five bits shift

	always_comb begin
		case (op)
			cpu_pkg::alu_add:
				y = a + b;
			cpu_pkg::alu_sub:
				y = a - b;
			cpu_pkg::alu_and:
				y = a & b;
			cpu_pkg::alu_or:
				y = a | b;
			cpu_pkg::alu_xor:
				y = a ^ b;
			cpu_pkg::alu_shl:
				y = a << shamt;
			cpu_pkg::alu_shr:
				y = a >> shamt;   // Logical shift with zero fill
			default:
				y = a;
		endcase
	end

	// Branch test for beqz, which passes rs1 through an add of zero
	assign zero = (y == '0);

endmodule

//--- design/cpu_host_port.sv
////////////////////////////////////////////////////////////////////////////
// APB slave of the core
// Instruction memory, run and clear control, status flags
// Retired instruction counter and error response
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_host_port (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [cpu_pkg::apb_aw-1:0]   paddr,
	input  logic [cpu_pkg::xlen-1:0]     pwdata,
	output logic [cpu_pkg::xlen-1:0]     prdata,
	output logic                         pready,
	output logic                         pslverr,
	input  cpu_pkg::pc_t                 fetch_pc,
	output cpu_pkg::instr_t              fetch_word,
	output logic [cpu_pkg::reg_aw-1:0]   host_reg,
	input  logic [cpu_pkg::xlen-1:0]     host_reg_data,
	output logic                         run_pulse,
	output logic                         clear_pulse,
	input  logic                         halted,
	input  logic                         retire
);

	logic [cpu_pkg::xlen-1:0] imem [cpu_pkg::imem_depth];
	logic [cpu_pkg::xlen-1:0] retired;
	logic                     running;
	logic                     done;
	logic                     access;
	logic                     sel_imem, sel_reg, sel_ctrl, sel_status, sel_retired;

	// Address decode
	assign sel_imem    = paddr[11:8] == cpu_pkg::imem_base[11:8];
	assign sel_reg     = paddr[11:6] == cpu_pkg::reg_base[11:6];
	assign sel_ctrl    = paddr == cpu_pkg::ctrl_addr;
	assign sel_status  = paddr == cpu_pkg::status_addr;
	assign sel_retired = paddr == cpu_pkg::retired_addr;

	assign access  = psel && penable;
	assign pready  = 1'b1;   // No wait states
	assign pslverr = access && (!(sel_imem || sel_reg || sel_ctrl || sel_status || sel_retired)
		|| (pwrite && sel_imem && running));

	assign host_reg    = paddr[5:2];
	assign run_pulse   = access && pwrite && sel_ctrl && pwdata[0];
	assign clear_pulse = access && pwrite && sel_ctrl && pwdata[1];
	assign fetch_word  = imem[fetch_pc];

	// Write-only locations read back as zero
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (sel_reg)
				prdata = host_reg_data;
			else if (sel_status)
				prdata = {{(cpu_pkg::xlen-2){1'b0}}, running, done};
			else if (sel_retired)
				prdata = retired;
		end
	end

	always_ff @(posedge clk) begin
		if (access && pwrite && sel_imem && !running)
			imem[paddr[7:2]] <= pwdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			done    <= 1'b0;
			retired <= '0;
		end else begin
			if (clear_pulse)
				retired <= '0;
			else if (retire)
				retired <= retired + 1'b1;
			if (run_pulse) begin
				running <= 1'b1;
				done    <= 1'b0;
			end else if (halted) begin
				running <= 1'b0;
				done    <= 1'b1;   // Halt reached write-back
			end else if (clear_pulse) begin
				done    <= 1'b0;
			end
		end
	end

endmodule

//--- design/cpu_pipeline.sv
////////////////////////////////////////////////////////////////////////////
// Five stage pipeline of the core
// Fetch and decode registers, execute with branch resolution
// Data memory access, write-back, halt and retire reporting
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_pipeline (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       run,
	input  logic                       clear,
	output cpu_pkg::pc_t               fetch_pc,
	input  cpu_pkg::instr_t            fetch_word,
	output cpu_pkg::instr_t            if_instr,
	input  logic                       rw_stall,
	input  logic                       jb_stall,
	cpu_stage_if.drv                   dec,
	cpu_stage_if.drv                   exec,
	cpu_stage_if.drv                   mem,
	cpu_stage_if.drv                   wb,
	output logic [cpu_pkg::reg_aw-1:0] ra_addr,
	output logic [cpu_pkg::reg_aw-1:0] rb_addr,
	input  logic [cpu_pkg::xlen-1:0]   ra_data,
	input  logic [cpu_pkg::xlen-1:0]   rb_data,
	output cpu_pkg::alu_op_t           alu_op,
	output logic [cpu_pkg::xlen-1:0]   alu_a,
	output logic [cpu_pkg::xlen-1:0]   alu_b,
	input  logic [cpu_pkg::xlen-1:0]   alu_y,
	input  logic                       alu_zero,
	output logic                       wr_en,
	output logic [cpu_pkg::reg_aw-1:0] wr_addr,
	output logic [cpu_pkg::xlen-1:0]   wr_data,
	output logic                       halted,
	output logic                       retire
);

	logic [cpu_pkg::xlen-1:0] dmem [cpu_pkg::dmem_depth];
	cpu_pkg::pc_t             pc, ex_tgt;
	logic                     fetching, advance, ex_taken;
	logic                     id_valid, ex_valid, mem_valid, wb_valid;
	cpu_pkg::instr_t          id_instr;
	cpu_pkg::opcode_t         id_op, ex_op, mem_op, wb_op;
	logic [cpu_pkg::reg_aw-1:0] ex_rd, mem_rd, wb_rd;
	logic [cpu_pkg::xlen-1:0] id_imm, ex_a, ex_b, ex_sd, mem_res, mem_sd, mem_data, wb_data;
	logic [cpu_pkg::dmem_aw-1:0] maddr;

	assign fetch_pc = pc;
	assign if_instr = fetch_word;
	assign advance  = fetching && !rw_stall && !jb_stall;

	// Decode operand selection
	assign id_op   = id_instr.r_fmt.opcode;
	assign id_imm  = {{16{id_instr.l_fmt.imm16[15]}}, id_instr.l_fmt.imm16};
	assign ra_addr = id_instr.r_fmt.rs1;
	assign rb_addr = cpu_pkg::is_store(id_op) ? id_instr.s_fmt.rs_data : id_instr.r_fmt.rs2;

	assign dec.valid    = id_valid;
	assign dec.wrt_reg  = id_instr.r_fmt.rd;
	assign dec.wrt_en   = id_valid && cpu_pkg::writes_reg(id_op);
	assign dec.jb_flag  = id_valid && cpu_pkg::is_jb(id_op);
	assign exec.valid   = ex_valid;
	assign exec.wrt_reg = ex_rd;
	assign exec.wrt_en  = ex_valid && cpu_pkg::writes_reg(ex_op);
	assign exec.jb_flag = ex_valid && cpu_pkg::is_jb(ex_op);
	assign mem.valid    = mem_valid;
	assign mem.wrt_reg  = mem_rd;
	assign mem.wrt_en   = mem_valid && cpu_pkg::writes_reg(mem_op);
	assign mem.jb_flag  = mem_valid && cpu_pkg::is_jb(mem_op);
	assign wb.valid     = wb_valid;
	assign wb.wrt_reg   = wb_rd;
	assign wb.wrt_en    = wb_valid && cpu_pkg::writes_reg(wb_op);
	assign wb.jb_flag   = wb_valid && cpu_pkg::is_jb(wb_op);

	always_comb begin
		case (ex_op)
			cpu_pkg::op_sub, cpu_pkg::op_subi: alu_op = cpu_pkg::alu_sub;
			cpu_pkg::op_and, cpu_pkg::op_andi: alu_op = cpu_pkg::alu_and;
			cpu_pkg::op_or,  cpu_pkg::op_ori:  alu_op = cpu_pkg::alu_or;
			cpu_pkg::op_xor, cpu_pkg::op_xori: alu_op = cpu_pkg::alu_xor;
			cpu_pkg::op_shl, cpu_pkg::op_shli: alu_op = cpu_pkg::alu_shl;
			cpu_pkg::op_shr:                   alu_op = cpu_pkg::alu_shr;
			default:                           alu_op = cpu_pkg::alu_add;   // Adds and addresses
		endcase
	end

	assign alu_a    = ex_a;
	assign alu_b    = ex_b;
	assign ex_taken = ex_valid && (ex_op == cpu_pkg::op_jmp ||
		(ex_op == cpu_pkg::op_beqz && alu_zero));

	// Memory stage with zero-extended byte access
	assign maddr = mem_res[cpu_pkg::dmem_aw-1:0];
	always_comb begin
		if (mem_op == cpu_pkg::op_ld)
			mem_data = dmem[maddr];
		else if (mem_op == cpu_pkg::op_ldb)
			mem_data = {{(cpu_pkg::xlen-8){1'b0}}, dmem[maddr][7:0]};
		else
			mem_data = mem_res;
	end

	assign wr_en   = wb.wrt_en;
	assign wr_addr = wb_rd;
	assign wr_data = wb_data;
	assign retire  = wb_valid;
	assign halted  = wb_valid && wb_op == cpu_pkg::op_halt;

	////////////////////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc        <= '0;
			fetching  <= 1'b0;
			id_valid  <= 1'b0;
			ex_valid  <= 1'b0;
			mem_valid <= 1'b0;
			wb_valid  <= 1'b0;
		end else if (run) begin   // Restart from word 0 with an empty pipe
			pc        <= '0;
			fetching  <= 1'b1;
			id_valid  <= 1'b0;
			ex_valid  <= 1'b0;
			mem_valid <= 1'b0;
			wb_valid  <= 1'b0;
		end else begin
			if (ex_taken)
				pc <= ex_tgt;
			else if (advance && fetch_word.r_fmt.opcode == cpu_pkg::op_halt)
				fetching <= 1'b0;   // Hold PC and insert bubbles
			else if (advance)
				pc <= pc + 1'b1;
			id_valid  <= advance;
			ex_valid  <= id_valid;
			mem_valid <= ex_valid;
			wb_valid  <= mem_valid;
		end
	end

	always_ff @(posedge clk) begin
		id_instr <= fetch_word;
		ex_op    <= id_op;
		ex_rd    <= id_instr.r_fmt.rd;
		ex_a     <= ra_data;
		ex_sd    <= rb_data;
		ex_tgt   <= id_instr.l_fmt.imm16[$bits(cpu_pkg::pc_t)-1:0];
		if (cpu_pkg::is_r_type(id_op))
			ex_b <= rb_data;
		else if (cpu_pkg::writes_reg(id_op) || cpu_pkg::is_store(id_op))
			ex_b <= id_imm;
		else
			ex_b <= '0;   // beqz tests rs1 alone
		mem_op   <= ex_op;
		mem_rd   <= ex_rd;
		mem_res  <= alu_y;
		mem_sd   <= ex_sd;
		wb_op    <= mem_op;
		wb_rd    <= mem_rd;
		wb_data  <= mem_data;
	end

	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < cpu_pkg::dmem_depth; i++)
				dmem[i] <= '0;
		end else if (mem_valid && mem_op == cpu_pkg::op_st) begin
			dmem[maddr] <= mem_sd;
		end else if (mem_valid && mem_op == cpu_pkg::op_stb) begin
			dmem[maddr] <= {{(cpu_pkg::xlen-8){1'b0}}, mem_sd[7:0]};
		end
	end

endmodule

//--- design/cpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Core sizes, opcodes and ALU operations
// Instruction word union with register, immediate and store views
// APB address map of the host port
// Opcode class helpers shared by the pipeline and the hazard unit
////////////////////////////////////////////////////////////////////////////
package cpu_pkg;

	localparam int xlen       = 32;
	localparam int reg_aw     = 4;
	localparam int imem_depth = 64;
	localparam int dmem_depth = 16;
	localparam int dmem_aw    = $clog2(dmem_depth);

	typedef logic [$clog2(imem_depth)-1:0] pc_t;   // Word index into imem

	// Unlisted values run as no-operation
	typedef enum logic [7:0] {
		op_add  = 8'h10, op_sub  = 8'h12, op_and  = 8'h14, op_or   = 8'h16,
		op_xor  = 8'h20, op_shl  = 8'h22, op_shr  = 8'h24,
		op_addi = 8'h11, op_subi = 8'h13, op_andi = 8'h15, op_xori = 8'h23,
		op_shli = 8'h25, op_ori  = 8'h27,
		op_ld   = 8'h81, op_ldb  = 8'h85, op_st   = 8'h83, op_stb  = 8'h87,
		op_jmp  = 8'h40, op_beqz = 8'h41, op_halt = 8'hFF
	} opcode_t;

	typedef struct packed {
		opcode_t            opcode;
		logic [reg_aw-1:0]  rd;
		logic [reg_aw-1:0]  rs1;
		logic [reg_aw-1:0]  rs2;
		logic [11:0]        unused;
	} r_fmt_t;

	typedef struct packed {
		opcode_t            opcode;
		logic [reg_aw-1:0]  rd;
		logic [reg_aw-1:0]  rs1;
		logic [15:0]        imm16;
	} l_fmt_t;

	typedef struct packed {
		opcode_t            opcode;
		logic [reg_aw-1:0]  rs_data;   // Register holding the store data
		logic [reg_aw-1:0]  rs_base;
		logic [15:0]        imm16;
	} s_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		l_fmt_t l_fmt;
		s_fmt_t s_fmt;
	} instr_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr
	} alu_op_t;

	////////////////////////////////////////////////////////////////////////////
	// APB byte addresses
	////////////////////////////////////////////////////////////////////////////
	localparam int apb_aw = 12;
	localparam logic [apb_aw-1:0] imem_base    = 12'h000;
	localparam logic [apb_aw-1:0] reg_base     = 12'h100;
	localparam logic [apb_aw-1:0] ctrl_addr    = 12'h140;
	localparam logic [apb_aw-1:0] status_addr  = 12'h144;
	localparam logic [apb_aw-1:0] retired_addr = 12'h148;

	function automatic logic is_r_type(input opcode_t op);
		return op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
	endfunction

	function automatic logic is_l_type(input opcode_t op);
		return op inside {op_addi, op_subi, op_andi, op_xori, op_shli, op_ori};
	endfunction

	function automatic logic is_load(input opcode_t op);
		return op inside {op_ld, op_ldb};
	endfunction

	function automatic logic is_store(input opcode_t op);
		return op inside {op_st, op_stb};
	endfunction

	function automatic logic is_jb(input opcode_t op);
		return op inside {op_jmp, op_beqz};
	endfunction

	function automatic logic writes_reg(input opcode_t op);
		return is_r_type(op) || is_l_type(op) || is_load(op);
	endfunction

endpackage

//--- design/cpu_regfile.sv
////////////////////////////////////////////////////////////////////////////
// Sixteen word register file
// Two operand read ports, one host read port, one write port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_regfile (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       clear,
	input  logic [cpu_pkg::reg_aw-1:0] ra_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rb_addr,
	input  logic [cpu_pkg::reg_aw-1:0] host_addr,
	output logic [cpu_pkg::xlen-1:0]   ra_data,
	output logic [cpu_pkg::xlen-1:0]   rb_data,
	output logic [cpu_pkg::xlen-1:0]   host_data,
	input  logic                       wr_en,
	input  logic [cpu_pkg::reg_aw-1:0] wr_addr,
	input  logic [cpu_pkg::xlen-1:0]   wr_data
);

	logic [cpu_pkg::xlen-1:0] regs [2**cpu_pkg::reg_aw];

	assign ra_data   = regs[ra_addr];
	assign rb_data   = regs[rb_addr];
	assign host_data = regs[host_addr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**cpu_pkg::reg_aw; i++)
				regs[i] <= '0;
		end else if (clear) begin
			for (int i = 0; i < 2**cpu_pkg::reg_aw; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;   // Write-back stage
		end
	end

endmodule

//--- design/cpu_stage_if.sv
////////////////////////////////////////////////////////////////////////////
// State of one pipeline stage as seen by the hazard unit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface cpu_stage_if;

	logic                       valid;     // Low for a bubble
	logic [cpu_pkg::reg_aw-1:0] wrt_reg;
	logic                       wrt_en;
	logic                       jb_flag;   // Stage holds jmp or beqz

	modport drv (
		output valid, wrt_reg, wrt_en, jb_flag
	);

	modport mon (
		input  valid, wrt_reg, wrt_en, jb_flag
	);

endinterface

//--- design/cpu_stall.sv
////////////////////////////////////////////////////////////////////////////
// Hazard unit of the core
// Read-after-write stall for the instruction in fetch
// Jump and branch stall while a control transfer is in flight
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_stall (
	input  cpu_pkg::instr_t if_instr,
	cpu_stage_if.mon        dec,
	cpu_stage_if.mon        exec,
	cpu_stage_if.mon        mem,
	cpu_stage_if.mon        wb,
	output logic            rw_stall,
	output logic            jb_stall
);

	logic [2**cpu_pkg::reg_aw-1:0] pend;   // Registers still to be written
	cpu_pkg::opcode_t              op;

	assign op = if_instr.r_fmt.opcode;

	always_comb begin
		pend = '0;
		if (dec.valid && dec.wrt_en)
			pend[dec.wrt_reg] = 1'b1;
		if (exec.valid && exec.wrt_en)
			pend[exec.wrt_reg] = 1'b1;
		if (mem.valid && mem.wrt_en)
			pend[mem.wrt_reg] = 1'b1;
		if (wb.valid && wb.wrt_en)
			pend[wb.wrt_reg] = 1'b1;   // No bypass around the write edge
	end

	// Store base register is not checked
	always_comb begin
		rw_stall = 1'b0;
		if (cpu_pkg::is_r_type(op))
			rw_stall = pend[if_instr.r_fmt.rs1] || pend[if_instr.r_fmt.rs2];
		else if (cpu_pkg::is_l_type(op) || cpu_pkg::is_load(op) || op == cpu_pkg::op_beqz)
			rw_stall = pend[if_instr.l_fmt.rs1];
		else if (cpu_pkg::is_store(op))
			rw_stall = pend[if_instr.s_fmt.rs_data];
	end

	assign jb_stall = dec.jb_flag || exec.jb_flag;

endmodule

//--- design/cpu_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the core with a plain APB host port
// Host port, pipeline, register file, ALU and hazard unit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [cpu_pkg::apb_aw-1:0] paddr,
	input  logic [cpu_pkg::xlen-1:0]   pwdata,
	output logic [cpu_pkg::xlen-1:0]   prdata,
	output logic                       pready,
	output logic                       pslverr
);

	cpu_pkg::pc_t               fetch_pc;
	cpu_pkg::instr_t            fetch_word, if_instr;
	cpu_pkg::alu_op_t           alu_op;
	logic [cpu_pkg::reg_aw-1:0] host_reg, ra_addr, rb_addr, wr_addr;
	logic [cpu_pkg::xlen-1:0]   host_reg_data, ra_data, rb_data, wr_data;
	logic [cpu_pkg::xlen-1:0]   alu_a, alu_b, alu_y;
	logic                       alu_zero, wr_en, rw_stall, jb_stall;
	logic                       run_pulse, clear_pulse, halted, retire;

	cpu_stage_if dec_if ();
	cpu_stage_if exec_if ();
	cpu_stage_if mem_if ();
	cpu_stage_if wb_if ();

	cpu_host_port u_host (
		.clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.fetch_pc, .fetch_word, .host_reg, .host_reg_data,
		.run_pulse, .clear_pulse, .halted, .retire
	);

	cpu_pipeline u_pipe (
		.clk, .arst_n, .run(run_pulse), .clear(clear_pulse),
		.fetch_pc, .fetch_word, .if_instr, .rw_stall, .jb_stall,
		.dec(dec_if.drv), .exec(exec_if.drv), .mem(mem_if.drv), .wb(wb_if.drv),
		.ra_addr, .rb_addr, .ra_data, .rb_data,
		.alu_op, .alu_a, .alu_b, .alu_y, .alu_zero,
		.wr_en, .wr_addr, .wr_data, .halted, .retire
	);

	cpu_regfile u_regs (
		.clk, .arst_n, .clear(clear_pulse),
		.ra_addr, .rb_addr, .host_addr(host_reg),
		.ra_data, .rb_data, .host_data(host_reg_data),
		.wr_en, .wr_addr, .wr_data
	);

	cpu_alu u_alu (
		.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y), .zero(alu_zero)
	);

	cpu_stall u_stall (
		.if_instr,
		.dec(dec_if.mon), .exec(exec_if.mon), .mem(mem_if.mon), .wb(wb_if.mon),
		.rw_stall, .jb_stall
	);

endmodule

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing -sv --top-module tb_cpu_top \
	-Mdir "$obj" -o tb_cpu_top -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$obj/tb_cpu_top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- verification/tb_cpu_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the core top level
// APB host driver, program table applied in a loop and result checks
// Reset, clear and host error response checks with a cycle timeout
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cpu_top;

	localparam int clk_period  = 100;
	localparam int n_tests     = 4;
	localparam int max_words   = 12;
	localparam int max_chk     = 4;
	localparam int cycle_limit = n_tests * (max_words * 40 + 400);
	localparam int seed        = 49411;

	logic                       clk = 1'b0;
	logic                       arst_n;
	logic                       psel, penable, pwrite;
	logic [cpu_pkg::apb_aw-1:0] paddr;
	logic [cpu_pkg::xlen-1:0]   pwdata;
	logic [cpu_pkg::xlen-1:0]   prdata;
	logic                       pready, pslverr;
	int                         errors = 0;
	int                         checks = 0;
	int                         cycle_count = 0;

	// Program table with one row per test
	string                      test_name   [n_tests];
	logic [cpu_pkg::xlen-1:0]   prog        [n_tests][max_words];
	int                         prog_len    [n_tests];
	logic [cpu_pkg::reg_aw-1:0] chk_reg     [n_tests][max_chk];
	logic [cpu_pkg::xlen-1:0]   chk_val     [n_tests][max_chk];
	int                         chk_cnt     [n_tests];
	logic [cpu_pkg::xlen-1:0]   exp_retired [n_tests];

	cpu_top DUT (
		.clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Error: run did not finish within %0d cycles", cycle_limit);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_word(input string name, input logic [cpu_pkg::xlen-1:0] exp,
		input logic [cpu_pkg::xlen-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error: %s expected pslverr %b actual %b", name, exp, act);
		end
	endtask

	// Status bits are {running, done}
	task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error: %s expected status %b actual %b", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB host driver
	////////////////////////////////////////////////////////////////////////////
	task automatic apb_xfer(input logic wr, input logic [cpu_pkg::apb_aw-1:0] addr,
		input logic [cpu_pkg::xlen-1:0] wdata, output logic [cpu_pkg::xlen-1:0] rdata,
		output logic err);
		@(negedge clk);
		psel    = 1'b1;   // Setup cycle
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(clk_period / 4);   // Mid access cycle
		rdata = prdata;
		err   = pslverr;
		if (pready !== 1'b1) begin
			errors++;
			$display("Error: pready was low in the access cycle at address %h", addr);
		end
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		repeat ($urandom_range(2, 0)) @(negedge clk);   // Random idle gap
	endtask

	task automatic apb_write(input logic [cpu_pkg::apb_aw-1:0] addr,
		input logic [cpu_pkg::xlen-1:0] data, output logic err);
		logic [cpu_pkg::xlen-1:0] unused_rdata;
		apb_xfer(1'b1, addr, data, unused_rdata, err);
	endtask

	task automatic apb_read(input logic [cpu_pkg::apb_aw-1:0] addr,
		output logic [cpu_pkg::xlen-1:0] data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding and table rows
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [cpu_pkg::xlen-1:0] r_word(input cpu_pkg::opcode_t op,
		input int rd, input int rs1, input int rs2);
		return {op, 4'(rd), 4'(rs1), 4'(rs2), 12'h000};
	endfunction

	// Immediate and store forms with rd as the store data register
	function automatic logic [cpu_pkg::xlen-1:0] i_word(input cpu_pkg::opcode_t op,
		input int rd, input int rs1, input int imm);
		return {op, 4'(rd), 4'(rs1), 16'(imm)};
	endfunction

	function automatic logic [cpu_pkg::xlen-1:0] nop_word();
		return {8'($urandom_range(15, 0)), 24'($urandom)};   // Opcodes below 0x10 are unused
	endfunction

	task automatic new_entry(input int t, input string name, input int retired);
		test_name[t]   = name;
		exp_retired[t] = 32'(retired);
		prog_len[t]    = 0;
		chk_cnt[t]     = 0;
	endtask

	task automatic put_word(input int t, input logic [cpu_pkg::xlen-1:0] w);
		prog[t][prog_len[t]] = w;
		prog_len[t]++;
	endtask

	task automatic expect_reg(input int t, input int r, input logic [cpu_pkg::xlen-1:0] v);
		chk_reg[t][chk_cnt[t]] = 4'(r);
		chk_val[t][chk_cnt[t]] = v;
		chk_cnt[t]++;
	endtask

	task automatic build_table();
		// Each R-type reads the result of the one before
		new_entry(0, "r_type_chain", 10);
		put_word(0, i_word(cpu_pkg::op_addi, 1, 0, 7));
		put_word(0, i_word(cpu_pkg::op_addi, 2, 0, 5));
		put_word(0, r_word(cpu_pkg::op_add, 3, 1, 2));   // 12
		put_word(0, r_word(cpu_pkg::op_sub, 4, 3, 1));   // 5
		put_word(0, r_word(cpu_pkg::op_xor, 5, 4, 3));   // 9
		put_word(0, r_word(cpu_pkg::op_or, 6, 5, 1));    // 15
		put_word(0, r_word(cpu_pkg::op_and, 7, 6, 2));   // 5
		put_word(0, r_word(cpu_pkg::op_shl, 8, 1, 2));   // 7 << 5
		put_word(0, r_word(cpu_pkg::op_shr, 9, 8, 1));   // 224 >> 7
		put_word(0, i_word(cpu_pkg::op_halt, 0, 0, 0));
		expect_reg(0, 4, 32'd5);
		expect_reg(0, 7, 32'd5);
		expect_reg(0, 8, 32'h0000_00E0);
		expect_reg(0, 9, 32'd1);

		new_entry(1, "imm_chain", 7);
		put_word(1, i_word(cpu_pkg::op_addi, 1, 0, -3));
		put_word(1, i_word(cpu_pkg::op_shli, 2, 1, 4));
		put_word(1, i_word(cpu_pkg::op_xori, 3, 2, 'h00FF));
		put_word(1, i_word(cpu_pkg::op_subi, 4, 3, -16));
		put_word(1, i_word(cpu_pkg::op_andi, 5, 4, 'h0FF0));
		put_word(1, i_word(cpu_pkg::op_ori, 6, 5, 'h8001));   // Sign bit set
		put_word(1, i_word(cpu_pkg::op_halt, 0, 0, 0));
		expect_reg(1, 2, 32'hFFFF_FFD0);
		expect_reg(1, 4, 32'hFFFF_FF3F);
		expect_reg(1, 5, 32'h0000_0F30);
		expect_reg(1, 6, 32'hFFFF_8F31);

		// Store base is r0, which stays zero
		new_entry(2, "load_store", 11);
		put_word(2, i_word(cpu_pkg::op_addi, 1, 0, 'h1234));
		put_word(2, i_word(cpu_pkg::op_shli, 1, 1, 16));
		put_word(2, i_word(cpu_pkg::op_ori, 1, 1, 'h5A6B));
		put_word(2, i_word(cpu_pkg::op_st, 1, 0, 3));
		put_word(2, i_word(cpu_pkg::op_stb, 1, 0, 5));
		put_word(2, i_word(cpu_pkg::op_addi, 2, 0, 1));
		put_word(2, i_word(cpu_pkg::op_ld, 3, 2, 2));
		put_word(2, i_word(cpu_pkg::op_ldb, 4, 0, 3));
		put_word(2, i_word(cpu_pkg::op_ld, 5, 0, 5));
		put_word(2, i_word(cpu_pkg::op_ld, 6, 2, -14));   // Wraps to word 3
		put_word(2, i_word(cpu_pkg::op_halt, 0, 0, 0));
		expect_reg(2, 3, 32'h1234_5A6B);
		expect_reg(2, 4, 32'h0000_006B);
		expect_reg(2, 5, 32'h0000_006B);
		expect_reg(2, 6, 32'h1234_5A6B);

		new_entry(3, "jump_branch", 7);
		put_word(3, i_word(cpu_pkg::op_addi, 1, 0, 1));
		put_word(3, i_word(cpu_pkg::op_jmp, 0, 0, 'h44));   // Target 68 wraps to 4
		put_word(3, i_word(cpu_pkg::op_addi, 2, 0, 'h22));
		put_word(3, i_word(cpu_pkg::op_addi, 2, 0, 'h33));
		put_word(3, i_word(cpu_pkg::op_beqz, 0, 1, 7));     // Not taken
		put_word(3, i_word(cpu_pkg::op_addi, 3, 0, 'h55));
		put_word(3, i_word(cpu_pkg::op_beqz, 0, 0, 9));     // Taken
		put_word(3, i_word(cpu_pkg::op_addi, 4, 0, 'h77));
		put_word(3, i_word(cpu_pkg::op_addi, 4, 0, 'h88));
		put_word(3, i_word(cpu_pkg::op_addi, 5, 3, 1));
		put_word(3, i_word(cpu_pkg::op_halt, 0, 0, 0));
		expect_reg(3, 2, 32'd0);
		expect_reg(3, 3, 32'h0000_0055);
		expect_reg(3, 4, 32'd0);
		expect_reg(3, 5, 32'h0000_0056);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////////////////////////////////////////
	task automatic fill_imem();
		logic err;
		for (int w = 0; w < cpu_pkg::imem_depth; w++) begin
			apb_write(cpu_pkg::imem_base + 12'(4 * w), nop_word(), err);
			check_err("imem fill", 1'b0, err);
		end
	endtask

	task automatic expect_cleared(input string tag);
		logic [cpu_pkg::xlen-1:0] rdata;
		logic                     err;
		for (int r = 0; r < 16; r++) begin
			apb_read(cpu_pkg::reg_base + 12'(4 * r), rdata, err);
			check_word($sformatf("%s r%0d", tag, r), '0, rdata);
		end
		apb_read(cpu_pkg::status_addr, rdata, err);
		check_status({tag, " status"}, 2'b00, rdata[1:0]);
		apb_read(cpu_pkg::retired_addr, rdata, err);
		check_word({tag, " retired"}, '0, rdata);
	endtask

	task automatic host_checks();
		logic [cpu_pkg::xlen-1:0] rdata;
		logic                     err;
		apb_read(12'h200, rdata, err);
		check_err("unmapped read", 1'b1, err);
		apb_write(12'h14C, 32'h1, err);
		check_err("unmapped write", 1'b1, err);
		apb_read(cpu_pkg::ctrl_addr, rdata, err);   // Write-only location reads zero
		check_word("ctrl read", '0, rdata);
		check_err("ctrl read", 1'b0, err);
		apb_read(cpu_pkg::imem_base + 12'h010, rdata, err);
		check_word("imem read", '0, rdata);
		check_err("imem read", 1'b0, err);
	endtask

	task automatic run_entry(input int t);
		logic [cpu_pkg::xlen-1:0] rdata;
		logic                     err;
		apb_write(cpu_pkg::ctrl_addr, 32'h2, err);   // Clear
		for (int w = 0; w < max_words; w++)
			apb_write(cpu_pkg::imem_base + 12'(4 * w),
				(w < prog_len[t]) ? prog[t][w] : nop_word(), err);
		apb_write(cpu_pkg::ctrl_addr, 32'h1, err);   // Run
		apb_read(cpu_pkg::status_addr, rdata, err);
		check_status({test_name[t], " running"}, 2'b10, rdata[1:0]);
		apb_write(cpu_pkg::imem_base + 12'h0FC, nop_word(), err);
		check_err({test_name[t], " imem write while running"}, 1'b1, err);
		do
			apb_read(cpu_pkg::status_addr, rdata, err);
		while (!rdata[0]);
		check_status({test_name[t], " done"}, 2'b01, rdata[1:0]);
		for (int c = 0; c < chk_cnt[t]; c++) begin
			apb_read(cpu_pkg::reg_base + 12'(4 * chk_reg[t][c]), rdata, err);
			check_word($sformatf("%s r%0d", test_name[t], chk_reg[t][c]), chk_val[t][c], rdata);
		end
		apb_read(cpu_pkg::retired_addr, rdata, err);
		check_word({test_name[t], " retired"}, exp_retired[t], rdata);
	endtask

	initial begin
		logic err;
		void'($urandom(seed));
		arst_n  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		build_table();
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		expect_cleared("after reset");
		fill_imem();
		host_checks();
		for (int t = 0; t < n_tests; t++)
			run_entry(t);
		apb_write(cpu_pkg::ctrl_addr, 32'h2, err);
		expect_cleared("after clear");
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
